/* logic/memCtrlPkg.sv */
package memCtrlPkg;

    // RAM and word geometry
    localparam int BYTE_WIDTH     = 8;
    localparam int WORD_WIDTH     = 32;
    localparam int BYTES_PER_WORD = WORD_WIDTH / BYTE_WIDTH;

    localparam int LEN_WIDTH   = 3;
    localparam int OWNER_WIDTH = 2;

    // one memory word, seen whole or as byte lanes (lane 0 is the low byte)
    typedef union packed {
        logic [WORD_WIDTH-1:0]                      word;
        logic [BYTES_PER_WORD-1:0][BYTE_WIDTH-1:0] bytes;
    } memWord_u;

    // data port length codes
    localparam logic [LEN_WIDTH-1:0] LEN_BYTE = 3'd1;
    localparam logic [LEN_WIDTH-1:0] LEN_HALF = 3'd2;
    localparam logic [LEN_WIDTH-1:0] LEN_WORD = 3'd4;

    // who owns the memory
    localparam logic [OWNER_WIDTH-1:0] OWNER_NONE  = 2'd0;
    localparam logic [OWNER_WIDTH-1:0] OWNER_DATA  = 2'd1;
    localparam logic [OWNER_WIDTH-1:0] OWNER_FETCH = 2'd2;

    // RAM direction
    localparam logic MEM_READ  = 1'b0;
    localparam logic MEM_WRITE = 1'b1;

    // data port direction
    localparam logic DIR_LOAD  = 1'b0;
    localparam logic DIR_STORE = 1'b1;

    // byte count of a length code, anything unknown counts as a full word
    function automatic logic [LEN_WIDTH-1:0] lenToBytes(input logic [LEN_WIDTH-1:0] len);
        logic [LEN_WIDTH-1:0] count;
        case (len)
            LEN_BYTE: count = 3'd1;
            LEN_HALF: count = 3'd2;
            default:  count = 3'd4;
        endcase
        return count;
    endfunction

endpackage

/* logic/reqArbiter.sv */
`timescale 1ns/1ns

module reqArbiter #(
    parameter int ADDR_WIDTH = 17
) (
    input  logic                                   clk,
    input  logic                                   rst,
    input  logic                                   i_stall,

    // data port request
    input  logic                                   i_dcEn,
    input  logic                                   i_dcDir,
    input  logic [memCtrlPkg::LEN_WIDTH-1:0]       i_dcLen,
    input  logic [ADDR_WIDTH-1:0]                  i_dcAddr,
    input  logic [memCtrlPkg::WORD_WIDTH-1:0]      i_dcData,

    // fetch request
    input  logic                                   i_infEn,
    input  logic [ADDR_WIDTH-1:0]                  i_infAddr,

    input  logic                                   i_seqDone,

    output logic                                   o_start,
    output logic                                   o_isFetch,
    output logic                                   o_isStore,
    output logic [memCtrlPkg::LEN_WIDTH-1:0]       o_len,
    output logic [ADDR_WIDTH-1:0]                  o_baseAddr,
    output memCtrlPkg::memWord_u                   o_storeWord,
    output logic [memCtrlPkg::OWNER_WIDTH-1:0]     o_owner
);

    logic idle;
    logic grantData;
    logic grantFetch;

    // owner code doubles as the busy flag
    assign idle = (o_owner == memCtrlPkg::OWNER_NONE);

    // data port wins a tie
    assign grantData  = idle && !i_stall && i_dcEn;
    assign grantFetch = idle && !i_stall && !i_dcEn && i_infEn;

    assign o_start   = grantData || grantFetch;
    assign o_isFetch = (o_owner == memCtrlPkg::OWNER_FETCH);

    always_ff @(posedge clk) begin
        if (rst) begin
            o_owner   <= memCtrlPkg::OWNER_NONE;
            o_isStore <= 1'b0;
        end else if (!i_stall) begin
            if (grantData) begin
                o_owner   <= memCtrlPkg::OWNER_DATA;
                o_isStore <= (i_dcDir == memCtrlPkg::DIR_STORE);
            end else if (grantFetch) begin
                o_owner   <= memCtrlPkg::OWNER_FETCH;
                o_isStore <= 1'b0;
            end else if (!idle && i_seqDone) begin
                // transaction over, back to idle
                o_owner   <= memCtrlPkg::OWNER_NONE;
                o_isStore <= 1'b0;
            end
        end
    end

    // request fields, held for the whole transaction
    always_ff @(posedge clk) begin
        if (grantData) begin
            o_baseAddr       <= i_dcAddr;
            o_len            <= i_dcLen;
            o_storeWord.word <= i_dcData;
        end else if (grantFetch) begin
            o_baseAddr <= i_infAddr;
            // a fetch is always a full word
            o_len      <= memCtrlPkg::LEN_WORD;
        end
    end

endmodule

/* logic/byteSequencer.sv */
`timescale 1ns/1ns

module byteSequencer #(
    parameter int ADDR_WIDTH = 17
) (
    input  logic                                   clk,
    input  logic                                   rst,
    input  logic                                   i_stall,
    input  logic                                   i_start,
    input  logic                                   i_isStore,
    input  logic [memCtrlPkg::LEN_WIDTH-1:0]       i_len,
    input  logic [ADDR_WIDTH-1:0]                  i_baseAddr,
    input  memCtrlPkg::memWord_u                   i_storeWord,

    // byte-wide RAM
    output logic [ADDR_WIDTH-1:0]                  o_memAddr,
    output logic                                   o_memRw,
    output logic [memCtrlPkg::BYTE_WIDTH-1:0]      o_memData,

    output logic [memCtrlPkg::LEN_WIDTH-1:0]       o_stage,
    output logic                                   o_done
);

    logic [memCtrlPkg::LEN_WIDTH-1:0] stage;
    logic [memCtrlPkg::LEN_WIDTH-1:0] numBytes;
    logic [memCtrlPkg::LEN_WIDTH-1:0] lastStage;
    logic [memCtrlPkg::LEN_WIDTH-1:0] offset;
    logic [1:0]                       laneIdx;
    logic                             busy;
    logic                             addrPhase;
    logic                             finalStage;

    assign numBytes = memCtrlPkg::lenToBytes(i_len);

    // reads need one extra stage for the last byte to come back
    assign lastStage = i_isStore ? numBytes : numBytes + 3'd1;

    assign busy       = (stage != '0);
    assign addrPhase  = busy && (stage <= numBytes);
    assign finalStage = busy && (stage == lastStage);

    // stage 1 drives the base address itself
    assign offset  = stage - 3'd1;
    assign laneIdx = offset[1:0];

    always_ff @(posedge clk) begin
        if (rst) begin
            stage <= '0;
        end else if (!i_stall) begin
            if (i_start) begin
                stage <= 3'd1;
            end else if (finalStage) begin
                stage <= '0;
            end else if (busy) begin
                stage <= stage + 3'd1;
            end
        end
    end

    always_comb begin
        o_memAddr = '0;
        o_memRw   = memCtrlPkg::MEM_READ;
        o_memData = '0;
        if (addrPhase && !i_stall) begin
            o_memAddr = i_baseAddr + ADDR_WIDTH'(offset);
            if (i_isStore) begin
                o_memRw   = memCtrlPkg::MEM_WRITE;
                o_memData = i_storeWord.bytes[laneIdx];
            end
        end
    end

    assign o_stage = stage;

    // no done while frozen
    assign o_done = finalStage && !i_stall;

endmodule

/* logic/wordAssembler.sv */
`timescale 1ns/1ns

module wordAssembler (
    input  logic                                   clk,
    input  logic                                   rst,
    input  logic                                   i_stall,
    input  logic [memCtrlPkg::LEN_WIDTH-1:0]       i_stage,
    input  logic                                   i_isFetch,
    input  logic                                   i_isStore,
    input  logic [memCtrlPkg::LEN_WIDTH-1:0]       i_len,
    input  logic [memCtrlPkg::BYTE_WIDTH-1:0]      i_memByte,
    input  logic                                   i_seqDone,

    // fetch result
    output logic                                   o_infDone,
    output logic [memCtrlPkg::WORD_WIDTH-1:0]      o_infInst,

    // data result
    output logic                                   o_dcDone,
    output logic [memCtrlPkg::WORD_WIDTH-1:0]      o_dcData
);

    memCtrlPkg::memWord_u             collected;
    memCtrlPkg::memWord_u             assembled;
    logic [memCtrlPkg::LEN_WIDTH-1:0] numBytes;
    logic [memCtrlPkg::LEN_WIDTH-1:0] laneOffset;
    logic                             captureByte;
    logic                             finish;

    assign numBytes = memCtrlPkg::lenToBytes(i_len);

    // byte returned in stage k belongs to lane k-2
    assign laneOffset  = i_stage - 3'd2;
    assign captureByte = !i_isStore && (i_stage >= 3'd2) && (i_stage <= numBytes);

    always_ff @(posedge clk) begin
        if (rst) begin
            collected.word <= '0;
        end else if (!i_stall) begin
            if (i_stage == 3'd1) begin
                // fresh transaction
                collected.word <= '0;
            end else if (captureByte) begin
                collected.bytes[laneOffset[1:0]] <= i_memByte;
            end
        end
    end

    // live byte goes in the top lane, anything above is zero
    always_comb begin
        int topLane;
        topLane = int'(numBytes) - 1;
        for (int lane = 0; lane < memCtrlPkg::BYTES_PER_WORD; lane++) begin
            if (lane < topLane) begin
                assembled.bytes[lane] = collected.bytes[lane];
            end else if (lane == topLane) begin
                assembled.bytes[lane] = i_memByte;
            end else begin
                assembled.bytes[lane] = '0;
            end
        end
    end

    assign finish = i_seqDone && !i_stall;

    assign o_infDone = finish && i_isFetch;
    assign o_infInst = o_infDone ? assembled.word : '0;

    // stores finish here too, only loads carry data
    assign o_dcDone = finish && !i_isFetch;
    assign o_dcData = (o_dcDone && !i_isStore) ? assembled.word : '0;

endmodule

/* logic/memCtrl.sv */
`timescale 1ns/1ns

module memCtrl #(
    parameter int ADDR_WIDTH = 17
) (
    input  logic                                   clk,
    input  logic                                   rst,
    input  logic                                   i_rdy,
    input  logic                                   i_ioBufferFull,

    // byte-wide RAM
    input  logic [memCtrlPkg::BYTE_WIDTH-1:0]      i_memData,
    output logic                                   o_memRw,
    output logic [ADDR_WIDTH-1:0]                  o_memAddr,
    output logic [memCtrlPkg::BYTE_WIDTH-1:0]      o_memData,

    output logic [memCtrlPkg::OWNER_WIDTH-1:0]     o_owner,

    // instruction fetch
    input  logic                                   i_infEn,
    input  logic [ADDR_WIDTH-1:0]                  i_infAddr,
    output logic                                   o_infDone,
    output logic [memCtrlPkg::WORD_WIDTH-1:0]      o_infInst,

    // data port
    input  logic                                   i_dcEn,
    input  logic                                   i_dcDir,
    input  logic [memCtrlPkg::LEN_WIDTH-1:0]       i_dcLen,
    input  logic [ADDR_WIDTH-1:0]                  i_dcAddr,
    input  logic [memCtrlPkg::WORD_WIDTH-1:0]      i_dcData,
    output logic                                   o_dcDone,
    output logic [memCtrlPkg::WORD_WIDTH-1:0]      o_dcData
);

    logic                                stall;
    logic                                start;
    logic                                isFetch;
    logic                                isStore;
    logic [memCtrlPkg::LEN_WIDTH-1:0]    len;
    logic [ADDR_WIDTH-1:0]               baseAddr;
    memCtrlPkg::memWord_u                storeWord;
    logic [memCtrlPkg::LEN_WIDTH-1:0]    stage;
    logic                                seqDone;

    // either condition freezes the whole controller
    assign stall = !i_rdy || i_ioBufferFull;

    reqArbiter #(.ADDR_WIDTH(ADDR_WIDTH)) arbiter0 (
        .clk        (clk),
        .rst        (rst),
        .i_stall    (stall),
        .i_dcEn     (i_dcEn),
        .i_dcDir    (i_dcDir),
        .i_dcLen    (i_dcLen),
        .i_dcAddr   (i_dcAddr),
        .i_dcData   (i_dcData),
        .i_infEn    (i_infEn),
        .i_infAddr  (i_infAddr),
        .i_seqDone  (seqDone),
        .o_start    (start),
        .o_isFetch  (isFetch),
        .o_isStore  (isStore),
        .o_len      (len),
        .o_baseAddr (baseAddr),
        .o_storeWord(storeWord),
        .o_owner    (o_owner)
    );

    byteSequencer #(.ADDR_WIDTH(ADDR_WIDTH)) sequencer0 (
        .clk        (clk),
        .rst        (rst),
        .i_stall    (stall),
        .i_start    (start),
        .i_isStore  (isStore),
        .i_len      (len),
        .i_baseAddr (baseAddr),
        .i_storeWord(storeWord),
        .o_memAddr  (o_memAddr),
        .o_memRw    (o_memRw),
        .o_memData  (o_memData),
        .o_stage    (stage),
        .o_done     (seqDone)
    );

    wordAssembler assembler0 (
        .clk      (clk),
        .rst      (rst),
        .i_stall  (stall),
        .i_stage  (stage),
        .i_isFetch(isFetch),
        .i_isStore(isStore),
        .i_len    (len),
        .i_memByte(i_memData),
        .i_seqDone(seqDone),
        .o_infDone(o_infDone),
        .o_infInst(o_infInst),
        .o_dcDone (o_dcDone),
        .o_dcData (o_dcData)
    );

endmodule

/* dv/ramModel.sv */
`timescale 1ns/1ns

module ramModel #(
    parameter int ADDR_WIDTH = 17
) (
    input  logic                              clk,
    input  logic                              i_en,
    input  logic                              i_rw,
    input  logic [ADDR_WIDTH-1:0]             i_addr,
    input  logic [memCtrlPkg::BYTE_WIDTH-1:0] i_wrData,
    output logic [memCtrlPkg::BYTE_WIDTH-1:0] o_rdData
);

    logic [memCtrlPkg::BYTE_WIDTH-1:0] mem [0:(1 << ADDR_WIDTH) - 1];

    // one cycle read latency, output held while the bus is not ready
    always @(posedge clk) begin
        if (i_en) begin
            if (i_rw == memCtrlPkg::MEM_WRITE) begin
                mem[i_addr] <= i_wrData;
            end
            o_rdData <= mem[i_addr];
        end
    end

    // backdoor write used for the preload
    task automatic preloadByte(
        input logic [ADDR_WIDTH-1:0]             addr,
        input logic [memCtrlPkg::BYTE_WIDTH-1:0] value
    );
        mem[addr] = value;
    endtask

    // backdoor read, no latency
    function automatic logic [memCtrlPkg::BYTE_WIDTH-1:0] peekByte(
        input logic [ADDR_WIDTH-1:0] addr
    );
        return mem[addr];
    endfunction

endmodule

/* dv/memCtrlTb.sv */
`timescale 1ns/1ns

module memCtrlTb;

    localparam int ADDR_WIDTH = 17;
    localparam int MEM_SIZE   = 1 << ADDR_WIDTH;
    localparam int TIMEOUT    = 100;
    localparam logic [8:0] LEN_CODES = {memCtrlPkg::LEN_WORD, memCtrlPkg::LEN_HALF,
                                        memCtrlPkg::LEN_BYTE};

    logic                                 clk;
    logic                                 rst;
    logic                                 rdy;
    logic                                 ioBufferFull;
    logic                                 stalled;
    logic [memCtrlPkg::BYTE_WIDTH-1:0]    ramRdData;
    logic                                 memRw;
    logic [ADDR_WIDTH-1:0]                memAddr;
    logic [memCtrlPkg::BYTE_WIDTH-1:0]    memWrData;
    logic [memCtrlPkg::OWNER_WIDTH-1:0]   owner;
    logic                                 infEn;
    logic [ADDR_WIDTH-1:0]                infAddr;
    logic                                 infDone;
    logic [memCtrlPkg::WORD_WIDTH-1:0]    infInst;
    logic                                 dcEn;
    logic                                 dcDir;
    logic [memCtrlPkg::LEN_WIDTH-1:0]     dcLen;
    logic [ADDR_WIDTH-1:0]                dcAddr;
    logic [memCtrlPkg::WORD_WIDTH-1:0]    dcWrData;
    logic                                 dcDone;
    logic [memCtrlPkg::WORD_WIDTH-1:0]    dcRdData;

    logic [15:0]                          lfsr;
    string                                testName;
    logic [memCtrlPkg::BYTE_WIDTH-1:0]    shadow [0:MEM_SIZE-1];
    memCtrlPkg::memWord_u                 expInfQ [$];
    memCtrlPkg::memWord_u                 expDcQ [$];
    logic                                 dcLoadQ [$];

    assign stalled = !rdy || ioBufferFull;

    always #4 clk = !clk;

    memCtrl #(.ADDR_WIDTH(ADDR_WIDTH)) dut0 (
        .clk           (clk),
        .rst           (rst),
        .i_rdy         (rdy),
        .i_ioBufferFull(ioBufferFull),
        .i_memData     (ramRdData),
        .o_memRw       (memRw),
        .o_memAddr     (memAddr),
        .o_memData     (memWrData),
        .o_owner       (owner),
        .i_infEn       (infEn),
        .i_infAddr     (infAddr),
        .o_infDone     (infDone),
        .o_infInst     (infInst),
        .i_dcEn        (dcEn),
        .i_dcDir       (dcDir),
        .i_dcLen       (dcLen),
        .i_dcAddr      (dcAddr),
        .i_dcData      (dcWrData),
        .o_dcDone      (dcDone),
        .o_dcData      (dcRdData)
    );

    ramModel #(.ADDR_WIDTH(ADDR_WIDTH)) ram0 (
        .clk     (clk),
        .i_en    (!stalled),
        .i_rw    (memRw),
        .i_addr  (memAddr),
        .i_wrData(memWrData),
        .o_rdData(ramRdData)
    );

    // galois LFSR stepped once per bit taken
    function automatic logic [31:0] randBits(input int count);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < count; i++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
            value = {value[30:0], lfsr[0]};
        end
        return value;
    endfunction

    function automatic int lenBytes(input logic [2:0] len);
        if (len == memCtrlPkg::LEN_BYTE || len == memCtrlPkg::LEN_HALF) begin
            return int'(len);
        end
        return 4;
    endfunction

    // expected load result as little-endian zero-extended bytes
    function automatic memCtrlPkg::memWord_u refRead(input logic [ADDR_WIDTH-1:0] addr,
                                                     input logic [2:0] len);
        memCtrlPkg::memWord_u result;
        result.word = '0;
        for (int k = 0; k < lenBytes(len); k++) begin
            result.bytes[k] = ram0.peekByte(ADDR_WIDTH'(addr + ADDR_WIDTH'(k)));
        end
        return result;
    endfunction

    function automatic memCtrlPkg::memWord_u shadowWord(input logic [ADDR_WIDTH-1:0] addr);
        memCtrlPkg::memWord_u result;
        for (int k = 0; k < 4; k++) begin
            result.bytes[k] = shadow[ADDR_WIDTH'(addr + ADDR_WIDTH'(k))];
        end
        return result;
    endfunction

    task automatic stopOnError();
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic checkWord(input string what, input memCtrlPkg::memWord_u expected,
                             input memCtrlPkg::memWord_u actual);
        if (actual.word !== expected.word) begin
            $display("error %s: expected %h, actual %h", what, expected.word, actual.word);
            stopOnError();
        end
    endtask

    task automatic checkOwner(input string what,
                              input logic [memCtrlPkg::OWNER_WIDTH-1:0] expected,
                              input logic [memCtrlPkg::OWNER_WIDTH-1:0] actual);
        if (actual !== expected) begin
            $display("error %s: expected %0d, actual %0d", what, expected, actual);
            stopOnError();
        end
    endtask

    task automatic checkByte(input string what,
                             input logic [memCtrlPkg::BYTE_WIDTH-1:0] expected,
                             input logic [memCtrlPkg::BYTE_WIDTH-1:0] actual);
        if (actual !== expected) begin
            $display("error %s: expected %h, actual %h", what, expected, actual);
            stopOnError();
        end
    endtask

    task automatic checkAddr(input string what, input logic [ADDR_WIDTH-1:0] expected,
                             input logic [ADDR_WIDTH-1:0] actual);
        if (actual !== expected) begin
            $display("error %s: expected %h, actual %h", what, expected, actual);
            stopOnError();
        end
    endtask

    task automatic checkFlag(input string what, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("error %s: expected %b, actual %b", what, expected, actual);
            stopOnError();
        end
    endtask

    // every result handed back is matched against the queued expectation
    always @(posedge clk) begin : compareResults
        memCtrlPkg::memWord_u expected;
        logic                 isLoad;
        if (!rst) begin
            if (stalled) begin
                checkFlag({testName, " done while stalled"}, 1'b0, infDone || dcDone);
                checkFlag({testName, " rw while stalled"}, memCtrlPkg::MEM_READ, memRw);
                checkAddr({testName, " address while stalled"}, '0, memAddr);
                checkByte({testName, " write data while stalled"}, '0, memWrData);
                checkWord({testName, " fetch result while stalled"}, '0, infInst);
                checkWord({testName, " data result while stalled"}, '0, dcRdData);
            end
            if (infDone) begin
                if (expInfQ.size() == 0) begin
                    $display("fetch done arrived with no fetch pending in %s", testName);
                    stopOnError();
                end else begin
                    expected = expInfQ.pop_front();
                    checkWord({testName, " fetch"}, expected, infInst);
                end
            end
            if (dcDone) begin
                if (expDcQ.size() == 0) begin
                    $display("data done arrived with no data request pending in %s", testName);
                    stopOnError();
                end else begin
                    expected = expDcQ.pop_front();
                    isLoad   = dcLoadQ.pop_front();
                    // only loads carry data back
                    if (isLoad) begin
                        checkWord({testName, " data"}, expected, dcRdData);
                    end
                end
            end
        end
    end

    // random freeze in about one cycle in four
    task automatic driveStall(input logic enable);
        logic [2:0] pick;
        rdy = 1'b1;
        ioBufferFull = 1'b0;
        if (enable) begin
            pick = randBits(3);
            if (pick[2:1] == 2'b11) begin
                rdy = pick[0];
                ioBufferFull = !pick[0];
            end
        end
    endtask

    task automatic runRequest(input logic isFetch, input logic dir, input logic [2:0] len,
                              input logic [ADDR_WIDTH-1:0] addr, input logic [31:0] data,
                              input memCtrlPkg::memWord_u expResult, input logic withStalls);
        logic [memCtrlPkg::OWNER_WIDTH-1:0] expOwner;
        int                                 expCycles;
        int                                 advCount;
        int                                 waited;
        logic                               accepted;
        logic                               done;
        expOwner  = isFetch ? memCtrlPkg::OWNER_FETCH : memCtrlPkg::OWNER_DATA;
        expCycles = lenBytes(isFetch ? memCtrlPkg::LEN_WORD : len);
        if (isFetch || dir == memCtrlPkg::DIR_LOAD) begin
            // reads wait one more cycle for the last byte
            expCycles = expCycles + 1;
        end
        advCount = 0;
        waited   = 0;
        accepted = 1'b0;
        done     = 1'b0;
        @(negedge clk);
        if (isFetch) begin
            expInfQ.push_back(expResult);
            infEn   = 1'b1;
            infAddr = addr;
        end else begin
            expDcQ.push_back(expResult);
            dcLoadQ.push_back(dir == memCtrlPkg::DIR_LOAD);
            dcEn     = 1'b1;
            dcDir    = dir;
            dcLen    = len;
            dcAddr   = addr;
            dcWrData = data;
        end
        driveStall(withStalls);
        while (!done) begin
            @(posedge clk);
            checkOwner({testName, " owner"}, accepted ? expOwner : memCtrlPkg::OWNER_NONE, owner);
            if (accepted && !stalled) begin
                advCount++;
            end
            if (isFetch ? infDone : dcDone) begin
                done = 1'b1;
                if (advCount != expCycles) begin
                    $display("error %s latency: expected %0d, actual %0d",
                             testName, expCycles, advCount);
                    stopOnError();
                end
            end
            if (!accepted && !stalled) begin
                accepted = 1'b1;
            end
            waited++;
            if (waited > TIMEOUT) begin
                $display("no done within %0d cycles in %s", TIMEOUT, testName);
                stopOnError();
            end
            @(negedge clk);
            driveStall(withStalls && !done);
        end
        infEn = 1'b0;
        dcEn  = 1'b0;
    endtask

    task automatic storeAndReadBack(input logic [2:0] len);
        logic [ADDR_WIDTH-1:0] addr;
        logic [ADDR_WIDTH-1:0] byteAddr;
        memCtrlPkg::memWord_u  data;
        addr      = randBits(ADDR_WIDTH);
        data.word = randBits(32);
        testName  = $sformatf("store len %0d", len);
        for (int k = 0; k < lenBytes(len); k++) begin
            byteAddr = ADDR_WIDTH'(addr + ADDR_WIDTH'(k));
            shadow[byteAddr] = data.bytes[k];
        end
        runRequest(1'b0, memCtrlPkg::DIR_STORE, len, addr, data.word, '0, 1'b1);
        for (int k = 0; k < 4; k++) begin
            byteAddr = ADDR_WIDTH'(addr + ADDR_WIDTH'(k));
            checkByte({testName, " ram byte"}, shadow[byteAddr], ram0.peekByte(byteAddr));
        end
        testName = $sformatf("load after store len %0d", len);
        runRequest(1'b0, memCtrlPkg::DIR_LOAD, memCtrlPkg::LEN_WORD, addr, '0,
                   shadowWord(addr), 1'b0);
    endtask

    // data goes first when both ports ask at once
    task automatic checkPriority();
        logic [ADDR_WIDTH-1:0]              fetchAddr;
        logic [ADDR_WIDTH-1:0]              loadAddr;
        logic [memCtrlPkg::OWNER_WIDTH-1:0] expOwner;
        int                                 n;
        int                                 cycle;
        logic                               finished;
        testName  = "priority";
        fetchAddr = randBits(ADDR_WIDTH);
        loadAddr  = randBits(ADDR_WIDTH);
        n         = lenBytes(memCtrlPkg::LEN_HALF);
        cycle     = 0;
        finished  = 1'b0;
        @(negedge clk);
        expDcQ.push_back(refRead(loadAddr, memCtrlPkg::LEN_HALF));
        dcLoadQ.push_back(1'b1);
        expInfQ.push_back(refRead(fetchAddr, memCtrlPkg::LEN_WORD));
        dcEn    = 1'b1;
        dcDir   = memCtrlPkg::DIR_LOAD;
        dcLen   = memCtrlPkg::LEN_HALF;
        dcAddr  = loadAddr;
        infEn   = 1'b1;
        infAddr = fetchAddr;
        while (!finished) begin
            @(posedge clk);
            if (cycle >= 1 && cycle <= n + 1) begin
                expOwner = memCtrlPkg::OWNER_DATA;
            end else if (cycle >= n + 3 && cycle <= n + 7) begin
                expOwner = memCtrlPkg::OWNER_FETCH;
            end else begin
                expOwner = memCtrlPkg::OWNER_NONE;
            end
            checkOwner("priority owner", expOwner, owner);
            checkFlag("priority data done", cycle == n + 1, dcDone);
            checkFlag("priority fetch done", cycle == n + 7, infDone);
            finished = infDone;
            cycle++;
            if (cycle > TIMEOUT) begin
                $display("fetch after data request never finished within %0d cycles", TIMEOUT);
                stopOnError();
            end
            @(negedge clk);
            if (cycle > n + 1) begin
                dcEn = 1'b0;
            end
            if (finished) begin
                infEn = 1'b0;
            end
        end
        @(posedge clk);
        checkOwner("priority idle owner", memCtrlPkg::OWNER_NONE, owner);
    endtask

    initial begin
        logic [ADDR_WIDTH-1:0] addr;
        logic [2:0]            len;
        clk          = 1'b0;
        rst          = 1'b1;
        rdy          = 1'b1;
        ioBufferFull = 1'b0;
        infEn        = 1'b0;
        infAddr      = '0;
        dcEn         = 1'b0;
        dcDir        = memCtrlPkg::DIR_LOAD;
        dcLen        = '0;
        dcAddr       = '0;
        dcWrData     = '0;
        lfsr         = 16'd65;
        testName     = "reset";
        for (int a = 0; a < MEM_SIZE; a++) begin
            shadow[a] = randBits(8);
            ram0.preloadByte(ADDR_WIDTH'(a), shadow[a]);
        end
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        @(posedge clk);
        checkOwner("reset owner", memCtrlPkg::OWNER_NONE, owner);
        checkFlag("reset rw", memCtrlPkg::MEM_READ, memRw);
        checkFlag("reset done", 1'b0, infDone || dcDone);

        testName = "fetch";
        addr = randBits(ADDR_WIDTH);
        runRequest(1'b1, memCtrlPkg::DIR_LOAD, memCtrlPkg::LEN_WORD, addr, '0,
                   refRead(addr, memCtrlPkg::LEN_WORD), 1'b0);

        for (int i = 0; i < 6; i++) begin
            len      = LEN_CODES[3 * (i % 3) +: 3];
            addr     = randBits(ADDR_WIDTH);
            testName = $sformatf("load len %0d", len);
            runRequest(1'b0, memCtrlPkg::DIR_LOAD, len, addr, '0, refRead(addr, len), 1'b0);
        end

        for (int i = 0; i < 3; i++) begin
            storeAndReadBack(LEN_CODES[3 * i +: 3]);
        end

        checkPriority();

        // fetches and loads with the bus freezing at random
        for (int i = 0; i < 12; i++) begin
            len  = LEN_CODES[3 * (i % 3) +: 3];
            addr = randBits(ADDR_WIDTH);
            if ((i % 2) == 1) begin
                testName = "stalled fetch";
                runRequest(1'b1, memCtrlPkg::DIR_LOAD, memCtrlPkg::LEN_WORD, addr, '0,
                           refRead(addr, memCtrlPkg::LEN_WORD), 1'b1);
            end else begin
                testName = $sformatf("stalled load len %0d", len);
                runRequest(1'b0, memCtrlPkg::DIR_LOAD, len, addr, '0, refRead(addr, len), 1'b1);
            end
        end

        $display("Test completed successfully");
        $finish;
    end

endmodule

/* memCtrl.f */
logic/memCtrlPkg.sv
logic/reqArbiter.sv
logic/byteSequencer.sv
logic/wordAssembler.sv
logic/memCtrl.sv
dv/ramModel.sv
dv/memCtrlTb.sv
